// File: verilog.f
+incdir+.
smi_pkg.sv
sample_fifo.sv
smi_ioc_regs.sv
smi_byte_counter.sv
smi_tx_fsm.sv
smi_tx_data.sv
smi_top.sv
tb_smi.sv

// File: Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing -f verilog.f --top-module tb_smi -o tb_smi
	./obj_dir/tb_smi | tee $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tb_smi.sv
`include "smi_settings.svh"

module tb_smi import smi_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TRAFFIC_WORDS = 40;
    localparam int TEST_BYTES    = 100;   // Longer than one LFSR period

    logic         i_sys_clk = 1'b0;
    logic         i_rst_b;
    logic         i_sample_push;
    sample_word_t i_sample_data;
    logic         o_fifo_full;
    ioc_addr_t    i_ioc;
    smi_byte_t    i_data_in;
    smi_byte_t    o_data_out;
    logic         i_cs;
    logic         i_fetch_cmd;
    logic         i_load_cmd;
    logic         o_channel;
    logic         o_address_error;
    logic         i_smi_soe_se;
    logic         i_smi_test;
    smi_byte_t    o_smi_data_out;
    logic         o_smi_read_req;

    // Model state
    sample_word_t sample_q[$];   // Pushed words not yet read by the host
    logic [31:0]  prod_rng;
    logic [31:0]  host_rng;
    smi_byte_t    exp_lfsr;
    byte_count_t  exp_count;

    smi_top UUT (.*);

    always #4 i_sys_clk = ~i_sys_clk;   // 8 ns period

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Test pattern step, shift right with bit 2 XOR bit 3 entering at the top
    function automatic smi_byte_t next_lfsr(input smi_byte_t v);
        smi_byte_t n;
        n    = v >> 1;
        n[7] = v[2] ^ v[3];
        if (n == 8'h00) begin
            n = `SMI_LFSR_SEED;   // Reload on zero
        end
        return n;
    endfunction

    task automatic abort_run();
        $display("sim failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            abort_run();
        end
    endtask

    task automatic wait_read_req(input logic level, input int limit);
        int n;
        n = 0;
        while (o_smi_read_req !== level) begin
            if (n == limit) begin
                $display("Timeout: o_smi_read_req did not reach %0d in %0d cycles", level, limit);
                abort_run();
            end
            n++;
            @(negedge i_sys_clk);
        end
    endtask

    task automatic fetch_reg(input ioc_addr_t addr, output smi_byte_t data);
        i_cs        = 1'b1;
        i_fetch_cmd = 1'b1;
        i_ioc       = addr;
        @(negedge i_sys_clk);
        i_cs        = 1'b0;
        i_fetch_cmd = 1'b0;
        data        = o_data_out;   // Registered on the edge in between
    endtask

    task automatic expect_reg(input ioc_addr_t addr, input smi_byte_t expected,
                              input string name);
        smi_byte_t data;
        fetch_reg(addr, data);
        compare_value(name, 32'(data), 32'(expected));
    endtask

    task automatic load_reg(input ioc_addr_t addr, input smi_byte_t data);
        i_cs       = 1'b1;
        i_load_cmd = 1'b1;
        i_ioc      = addr;
        i_data_in  = data;
        @(negedge i_sys_clk);
        i_cs       = 1'b0;
        i_load_cmd = 1'b0;
    endtask

    // Host side of one byte, check then strobe
    task automatic take_byte(input smi_byte_t expected);
        compare_value("o_smi_read_req", 32'(o_smi_read_req), 32'd1);
        compare_value("o_smi_data_out", 32'(o_smi_data_out), 32'(expected));
        host_rng = xorshift(host_rng);
        i_smi_soe_se = 1'b0;
        repeat (1 + host_rng[1:0]) @(negedge i_sys_clk);   // Low for 1 to 4 cycles
        i_smi_soe_se = 1'b1;
        repeat (6 + host_rng[3:2]) @(negedge i_sys_clk);   // Gap of at least 6
        exp_count = exp_count + 1'b1;
    endtask

    task automatic push_words(input int n);
        int guard;
        for (int w = 0; w < n; w++) begin
            prod_rng = xorshift(prod_rng);
            repeat (prod_rng[2:0]) @(negedge i_sys_clk);
            guard = 0;
            while (o_fifo_full) begin   // Producer holds off instead of losing words
                if (guard == 1000) begin
                    $display("Timeout: FIFO stayed full for 1000 cycles");
                    abort_run();
                end
                guard++;
                @(negedge i_sys_clk);
            end
            prod_rng = xorshift(prod_rng);
            i_sample_push = 1'b1;
            i_sample_data = prod_rng;
            sample_q.push_back(prod_rng);
            @(negedge i_sys_clk);
            i_sample_push = 1'b0;
        end
    endtask

    // One push per cycle with no host reads, then one push into a full FIFO
    task automatic overfill_fifo();
        for (int w = 0; w <= `SMI_FIFO_DEPTH; w++) begin
            compare_value("o_fifo_full", 32'(o_fifo_full), 32'd0);
            prod_rng = xorshift(prod_rng);
            i_sample_push = 1'b1;
            i_sample_data = prod_rng;
            sample_q.push_back(prod_rng);
            @(negedge i_sys_clk);
        end
        // First word sits in the holding register, the rest fill the FIFO
        compare_value("o_fifo_full", 32'(o_fifo_full), 32'd1);
        prod_rng = xorshift(prod_rng);
        i_sample_data = prod_rng;   // Dropped, never read back
        @(negedge i_sys_clk);
        i_sample_push = 1'b0;
        compare_value("o_fifo_full", 32'(o_fifo_full), 32'd1);
    endtask

    task automatic read_words(input int n);
        sample_word_t word;
        for (int w = 0; w < n; w++) begin
            wait_read_req(1'b1, 400);
            if (sample_q.size() == 0) begin
                $display("Read request raised although no word was pushed");
                abort_run();
            end
            word = sample_q.pop_front();
            for (int i = 0; i < 4; i++) begin
                take_byte(word[31 - 8*i -: 8]);   // MSB first
            end
        end
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        i_rst_b       = 1'b0;
        i_sample_push = 1'b0;
        i_sample_data = '0;
        i_ioc         = '0;
        i_data_in     = '0;
        i_cs          = 1'b0;
        i_fetch_cmd   = 1'b0;
        i_load_cmd    = 1'b0;
        i_smi_soe_se  = 1'b1;   // Strobe idles high
        i_smi_test    = 1'b0;
        prod_rng      = 32'd63;
        host_rng      = 32'd63 ^ 32'h5a5a_5a5a;   // Separate host stream
        exp_lfsr      = `SMI_LFSR_SEED;
        exp_count     = '0;
        repeat (5) @(negedge i_sys_clk);
        i_rst_b = 1'b1;
        @(negedge i_sys_clk);

        // Reset state
        compare_value("o_smi_read_req", 32'(o_smi_read_req), 32'd0);
        compare_value("o_channel", 32'(o_channel), 32'd0);
        compare_value("o_address_error", 32'(o_address_error), 32'd0);
        compare_value("o_fifo_full", 32'(o_fifo_full), 32'd0);
        expect_reg(`SMI_IOC_VERSION, `SMI_MODULE_VERSION, "version");
        expect_reg(`SMI_IOC_COUNT_LO, 8'h00, "count_lo");
        expect_reg(`SMI_IOC_FIFO_STATUS, 8'h01, "fifo_status");

        // Channel bit, then status with one word held and one waiting
        load_reg(`SMI_IOC_CHANNEL, 8'hff);
        compare_value("o_channel", 32'(o_channel), 32'd1);
        expect_reg(`SMI_IOC_CHANNEL, 8'h01, "channel");
        push_words(2);
        wait_read_req(1'b1, 20);
        expect_reg(`SMI_IOC_FIFO_STATUS, {6'd0, 1'b1, 1'(sample_q.size() < 2)}, "fifo_status");
        read_words(2);

        // Random traffic with back-pressure
        fork
            push_words(TRAFFIC_WORDS);
            read_words(TRAFFIC_WORDS);
        join

        // Full flag and dropped push
        overfill_fifo();
        read_words(`SMI_FIFO_DEPTH + 1);
        compare_value("o_smi_read_req", 32'(o_smi_read_req), 32'd0);
        compare_value("o_fifo_full", 32'(o_fifo_full), 32'd0);

        expect_reg(`SMI_IOC_FIFO_STATUS, 8'h03, "fifo_status");
        expect_reg(`SMI_IOC_COUNT_LO, exp_count[7:0], "count_lo");
        expect_reg(`SMI_IOC_COUNT_HI, exp_count[15:8], "count_hi");

        // LFSR test pattern
        i_smi_test = 1'b1;
        wait_read_req(1'b1, 20);
        for (int k = 0; k < TEST_BYTES; k++) begin
            take_byte(exp_lfsr);
            exp_lfsr = next_lfsr(exp_lfsr);
        end
        i_smi_test = 1'b0;
        wait_read_req(1'b0, 20);
        expect_reg(`SMI_IOC_COUNT_LO, exp_count[7:0], "count_lo");
        expect_reg(`SMI_IOC_COUNT_HI, exp_count[15:8], "count_hi");

        // Unmapped address sets the sticky error
        expect_reg(5'd9, 8'h00, "data_out");
        compare_value("o_address_error", 32'(o_address_error), 32'd1);
        expect_reg(`SMI_IOC_VERSION, `SMI_MODULE_VERSION, "version");
        compare_value("o_address_error", 32'(o_address_error), 32'd1);

        $display("sim passed");
        $finish;
    end

endmodule

// File: smi_top.sv
module smi_top import smi_pkg::*; (
    input  logic         i_sys_clk,
    input  logic         i_rst_b,

    // Producer
    input  logic         i_sample_push,
    input  sample_word_t i_sample_data,
    output logic         o_fifo_full,

    // Command bus
    input  ioc_addr_t    i_ioc,
    input  smi_byte_t    i_data_in,
    output smi_byte_t    o_data_out,
    input  logic         i_cs,
    input  logic         i_fetch_cmd,
    input  logic         i_load_cmd,
    output logic         o_channel,
    output logic         o_address_error,

    // SMI host
    input  logic         i_smi_soe_se,
    input  logic         i_smi_test,
    output smi_byte_t    o_smi_data_out,
    output logic         o_smi_read_req
);

    logic         fifo_empty;
    sample_word_t fifo_word;
    logic         fifo_pop;
    logic         load;
    logic         byte_taken;
    logic         test_active;
    logic         sending;
    byte_lane_t   lane;
    logic         last_lane;
    byte_count_t  byte_count;

    // Host is asked to read while a word or test byte is up
    assign o_smi_read_req = sending | test_active;

    sample_fifo u_fifo (
        .i_sys_clk   (i_sys_clk),
        .i_rst_b     (i_rst_b),
        .i_push      (i_sample_push),
        .i_push_data (i_sample_data),
        .i_pop       (fifo_pop),
        .o_head      (fifo_word),
        .o_empty     (fifo_empty),
        .o_full      (o_fifo_full)
    );

    smi_tx_fsm u_fsm (
        .i_sys_clk     (i_sys_clk),
        .i_rst_b       (i_rst_b),
        .i_smi_soe_se  (i_smi_soe_se),
        .i_smi_test    (i_smi_test),
        .i_fifo_empty  (fifo_empty),
        .i_last_lane   (last_lane),
        .o_fifo_pop    (fifo_pop),
        .o_load        (load),
        .o_byte_taken  (byte_taken),
        .o_test_active (test_active),
        .o_sending     (sending)
    );

    smi_byte_counter u_counter (
        .i_sys_clk    (i_sys_clk),
        .i_rst_b      (i_rst_b),
        .i_load       (load),
        .i_byte_taken (byte_taken),
        .i_sending    (sending),
        .o_lane       (lane),
        .o_last_lane  (last_lane),
        .o_byte_count (byte_count)
    );

    smi_tx_data u_data (
        .i_sys_clk     (i_sys_clk),
        .i_rst_b       (i_rst_b),
        .i_load        (load),
        .i_word        (fifo_word),
        .i_lane        (lane),
        .i_byte_taken  (byte_taken),
        .i_test_active (test_active),
        .o_byte        (o_smi_data_out)
    );

    smi_ioc_regs u_regs (
        .i_sys_clk       (i_sys_clk),
        .i_rst_b         (i_rst_b),
        .i_ioc           (i_ioc),
        .i_data_in       (i_data_in),
        .i_cs            (i_cs),
        .i_fetch_cmd     (i_fetch_cmd),
        .i_load_cmd      (i_load_cmd),
        .i_fifo_empty    (fifo_empty),
        .i_byte_count    (byte_count),
        .o_data_out      (o_data_out),
        .o_channel       (o_channel),
        .o_address_error (o_address_error)
    );

endmodule

// File: smi_tx_data.sv
`include "smi_settings.svh"

module smi_tx_data import smi_pkg::*; (
    input  logic         i_sys_clk,
    input  logic         i_rst_b,

    input  logic         i_load,
    input  sample_word_t i_word,
    input  byte_lane_t   i_lane,
    input  logic         i_byte_taken,
    input  logic         i_test_active,

    output smi_byte_t    o_byte
);

    sample_word_t word_q;      // Word being sent
    smi_byte_t    word_byte;
    smi_byte_t    lfsr;
    smi_byte_t    lfsr_step;

    // Holding register
    always_ff @(posedge i_sys_clk) begin
        if (i_load) begin
            word_q <= i_word;
        end
    end

    // MSB first
    always_comb begin
        unique case (i_lane)
            2'd0:    word_byte = word_q[31:24];
            2'd1:    word_byte = word_q[23:16];
            2'd2:    word_byte = word_q[15:8];
            default: word_byte = word_q[7:0];
        endcase
    end

    // ------------------------------------------------------------
    // Test pattern
    // ------------------------------------------------------------
    assign lfsr_step = {lfsr[2] ^ lfsr[3], lfsr[7:1]};   // Feedback into bit 7

    always_ff @(posedge i_sys_clk or negedge i_rst_b) begin
        if (!i_rst_b) begin
            lfsr <= `SMI_LFSR_SEED;
        end else if (i_test_active && i_byte_taken) begin
            if (lfsr_step == '0) begin
                lfsr <= `SMI_LFSR_SEED;   // Never let it lock up at zero
            end else begin
                lfsr <= lfsr_step;
            end
        end
    end

    assign o_byte = i_test_active ? lfsr : word_byte;

endmodule

// File: smi_tx_fsm.sv
module smi_tx_fsm import smi_pkg::*; (
    input  logic i_sys_clk,
    input  logic i_rst_b,

    input  logic i_smi_soe_se,
    input  logic i_smi_test,
    input  logic i_fifo_empty,
    input  logic i_last_lane,

    output logic o_fifo_pop,
    output logic o_load,
    output logic o_byte_taken,
    output logic o_test_active,
    output logic o_sending
);

    tx_state_t state;
    tx_state_t state_next;

    logic soe_meta;
    logic soe_sync;
    logic soe_prev;
    logic soe_fall;      // Registered falling edge of the strobe
    logic test_meta;
    logic test_sync;

    // ------------------------------------------------------------
    // Host strobe and test mode synchronizers
    // ------------------------------------------------------------
    always_ff @(posedge i_sys_clk or negedge i_rst_b) begin
        if (!i_rst_b) begin
            soe_meta  <= 1'b1;   // Strobe idles high
            soe_sync  <= 1'b1;
            soe_prev  <= 1'b1;
            soe_fall  <= 1'b0;
            test_meta <= 1'b0;
            test_sync <= 1'b0;
        end else begin
            soe_meta  <= i_smi_soe_se;
            soe_sync  <= soe_meta;
            soe_prev  <= soe_sync;
            soe_fall  <= soe_prev & ~soe_sync;   // Third edge after the pin
            test_meta <= i_smi_test;
            test_sync <= test_meta;
        end
    end

    // ------------------------------------------------------------
    // Sequencer
    // ------------------------------------------------------------
    always_ff @(posedge i_sys_clk or negedge i_rst_b) begin
        if (!i_rst_b) begin
            state <= TX_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        unique case (state)
            TX_IDLE: begin
                // Test mode only at a word boundary
                if (test_sync) begin
                    state_next = TX_TEST;
                end else if (!i_fifo_empty) begin
                    state_next = TX_LOAD;
                end
            end
            TX_LOAD: begin
                state_next = TX_SEND;   // Single cycle pop
            end
            TX_SEND: begin
                if (soe_fall && i_last_lane) begin
                    state_next = TX_IDLE;
                end
            end
            TX_TEST: begin
                if (!test_sync) begin
                    state_next = TX_IDLE;
                end
            end
            default: state_next = TX_IDLE;
        endcase
    end

    assign o_load        = (state == TX_LOAD);
    assign o_fifo_pop    = (state == TX_LOAD);
    assign o_sending     = (state == TX_SEND);
    assign o_test_active = (state == TX_TEST);

    // Strobes outside a transfer are not counted
    assign o_byte_taken  = soe_fall & (o_sending | o_test_active);

endmodule

// File: smi_byte_counter.sv
module smi_byte_counter import smi_pkg::*; (
    input  logic        i_sys_clk,
    input  logic        i_rst_b,

    input  logic        i_load,
    input  logic        i_byte_taken,
    input  logic        i_sending,

    output byte_lane_t  o_lane,
    output logic        o_last_lane,
    output byte_count_t o_byte_count
);

    assign o_last_lane = (o_lane == 2'd3);   // LSB of the word

    // Lane within the current word
    always_ff @(posedge i_sys_clk or negedge i_rst_b) begin
        if (!i_rst_b) begin
            o_lane <= '0;
        end else if (i_load) begin
            o_lane <= '0;                    // New word starts at MSB
        end else if (i_byte_taken && i_sending) begin
            o_lane <= o_lane + 1'b1;
        end
    end

    // Delivered bytes, samples and test pattern alike
    always_ff @(posedge i_sys_clk or negedge i_rst_b) begin
        if (!i_rst_b) begin
            o_byte_count <= '0;
        end else if (i_byte_taken) begin
            o_byte_count <= o_byte_count + 1'b1;   // Wraps at 16 bits
        end
    end

endmodule

// File: smi_ioc_regs.sv
`include "smi_settings.svh"

module smi_ioc_regs import smi_pkg::*; (
    input  logic        i_sys_clk,
    input  logic        i_rst_b,

    input  ioc_addr_t   i_ioc,
    input  smi_byte_t   i_data_in,
    input  logic        i_cs,
    input  logic        i_fetch_cmd,
    input  logic        i_load_cmd,

    input  logic        i_fifo_empty,
    input  byte_count_t i_byte_count,

    output smi_byte_t   o_data_out,
    output logic        o_channel,
    output logic        o_address_error
);

    logic fetch;
    logic load;

    assign fetch = i_cs & i_fetch_cmd;
    assign load  = i_cs & i_load_cmd & ~i_fetch_cmd;   // Fetch wins

    always_ff @(posedge i_sys_clk or negedge i_rst_b) begin
        if (!i_rst_b) begin
            o_data_out      <= '0;
            o_channel       <= 1'b0;
            o_address_error <= 1'b0;
        end else begin
            // ------------------------------------------------------------
            // Register reads
            // ------------------------------------------------------------
            if (fetch) begin
                case (i_ioc)
                    `SMI_IOC_VERSION: begin
                        o_data_out <= `SMI_MODULE_VERSION;
                    end
                    `SMI_IOC_FIFO_STATUS: begin
                        o_data_out <= {6'b000000, o_channel, i_fifo_empty};
                    end
                    `SMI_IOC_CHANNEL: begin
                        o_data_out <= {7'b0000000, o_channel};
                    end
                    `SMI_IOC_COUNT_LO: begin
                        o_data_out <= i_byte_count[7:0];
                    end
                    `SMI_IOC_COUNT_HI: begin
                        o_data_out <= i_byte_count[15:8];
                    end
                    default: begin
                        o_data_out      <= '0;
                        o_address_error <= 1'b1;   // Unmapped, stays set
                    end
                endcase
            end

            // ------------------------------------------------------------
            // Register writes
            // ------------------------------------------------------------
            if (load) begin
                case (i_ioc)
                    `SMI_IOC_CHANNEL: begin
                        o_channel <= i_data_in[0];
                    end
                    default: begin
                        // Read-only or unmapped target
                        o_address_error <= 1'b1;
                    end
                endcase
            end
        end
    end

endmodule

// File: sample_fifo.sv
`include "smi_settings.svh"

module sample_fifo import smi_pkg::*; #(
    parameter int DEPTH = `SMI_FIFO_DEPTH
) (
    input  logic         i_sys_clk,
    input  logic         i_rst_b,

    input  logic         i_push,
    input  sample_word_t i_push_data,
    input  logic         i_pop,

    output sample_word_t o_head,
    output logic         o_empty,
    output logic         o_full
);

    localparam int AW = $clog2(DEPTH);

    sample_word_t    mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [AW:0]     count;     // One extra bit to tell full from empty
    logic            push_ok;
    logic            pop_ok;

    assign push_ok = i_push & ~o_full;   // Drop pushes when full
    assign pop_ok  = i_pop & ~o_empty;   // Ignore pops when empty

    assign o_empty = (count == '0);
    assign o_full  = (count == (AW+1)'(DEPTH));
    assign o_head  = mem[rd_ptr];        // First word falls through

    // ------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------
    always_ff @(posedge i_sys_clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= i_push_data;
        end
    end

    // ------------------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------------------
    always_ff @(posedge i_sys_clk or negedge i_rst_b) begin
        if (!i_rst_b) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;   // Wraps at power-of-two depth
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            unique case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Both or neither
            endcase
        end
    end

endmodule

// File: smi_pkg.sv
package smi_pkg;

    // Data widths
    typedef logic [31:0] sample_word_t;   // One producer sample
    typedef logic [7:0]  smi_byte_t;      // SMI bus or command bus byte
    typedef logic [4:0]  ioc_addr_t;      // Command bus register address

    // Byte position within a sample word, lane 0 is the MSB
    typedef logic [1:0]  byte_lane_t;

    // Running total of bytes handed to the host
    typedef logic [15:0] byte_count_t;

    // Read-out sequencer states
    typedef enum logic [1:0] {
        TX_IDLE = 2'd0,   // Waiting for data or test mode
        TX_LOAD = 2'd1,   // Pop head word into holding register
        TX_SEND = 2'd2,   // Host pulls the four bytes
        TX_TEST = 2'd3    // LFSR pattern instead of samples
    } tx_state_t;

endpackage

// File: smi_settings.svh
`ifndef SMI_SETTINGS_SVH
`define SMI_SETTINGS_SVH

// ------------------------------------------------------------
// Module identity and sizing
// ------------------------------------------------------------
`define SMI_MODULE_VERSION  8'h01
`define SMI_FIFO_DEPTH      16      // Sample words, power of two
`define SMI_LFSR_SEED       8'h56   // Test pattern start and reload value

// ------------------------------------------------------------
// IOC register map
// ------------------------------------------------------------
`define SMI_IOC_VERSION     5'd0    // Read only
`define SMI_IOC_FIFO_STATUS 5'd1    // Read only
`define SMI_IOC_CHANNEL     5'd2    // Read and write
`define SMI_IOC_COUNT_LO    5'd3    // Read only
`define SMI_IOC_COUNT_HI    5'd4    // Read only

`endif
